// ==== design/arcade_shell_top.sv ====
// Arcade board shell top level
`default_nettype none
`timescale 1ns/1ns

module arcade_shell_top (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire shell_pkg::status_word_t  status,
	input  wire [1:0]                     menu_buttons,
	input  wire                           ps2_kbd_clk,
	input  wire                           ps2_kbd_data,
	input  wire shell_pkg::joystick_t     joystick_0,
	input  wire shell_pkg::joystick_t     joystick_1,
	input  wire shell_pkg::core_pixel_t   core_pixel,
	input  wire                           ce_pix,
	input  wire                           hsync,
	input  wire                           vsync,
	input  wire                           hblank,
	input  wire                           vblank,
	input  wire shell_pkg::audio_sample_t audio,
	output logic                          core_reset,
	output shell_pkg::cabinet_buttons_t   cabinet_buttons,
	output shell_pkg::vga_out_t           vga,
	output logic                          audio_l,
	output logic                          audio_r
);

	import shell_pkg::*;

	logic       upright;
	scan_mode_t scan_mode;
	key_state_t key_state;

	// ========================================
	// Control
	// ========================================
	shell_control u_control (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.status       (status),
		.menu_buttons (menu_buttons),
		.vblank       (vblank),
		.core_reset   (core_reset),
		.upright      (upright),
		.scan_mode    (scan_mode)
	);

	// ========================================
	// Player inputs
	// ========================================
	ps2_keyboard u_keyboard (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.key_state    (key_state)
	);

	player_input_mapper u_mapper (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.key_state       (key_state),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.upright         (upright),
		.cabinet_buttons (cabinet_buttons)
	);

	// ========================================
	// Video and audio
	// ========================================
	pixel_output u_pixel (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ce_pix     (ce_pix),
		.core_pixel (core_pixel),
		.hsync      (hsync),
		.vsync      (vsync),
		.hblank     (hblank),
		.vblank     (vblank),
		.scan_mode  (scan_mode),
		.vga        (vga)
	);

	sigma_delta_dac u_dac (
		.clk_sys (clk_sys),
		.reset   (reset),
		.audio   (audio),
		.dac_out (audio_l)
	);

	// Mono core, both channels carry the same bitstream
	assign audio_r = audio_l;

endmodule

`default_nettype wire

// ==== design/pixel_output.sv ====
// VGA pixel output stage
`default_nettype none
`timescale 1ns/1ns

module pixel_output (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         ce_pix,
	input  wire shell_pkg::core_pixel_t core_pixel,
	input  wire                         hsync,
	input  wire                         vsync,
	input  wire                         hblank,
	input  wire                         vblank,
	input  wire shell_pkg::scan_mode_t  scan_mode,
	output shell_pkg::vga_out_t         vga
);

	import shell_pkg::*;

	vga_color_t exp_r;
	vga_color_t exp_g;
	vga_color_t exp_b;
	logic       blank;
	logic       odd_line;

	// Darken a channel on odd lines to mimic CRT scanlines
	function automatic vga_color_t shade(input vga_color_t v, input scan_mode_t mode,
	                                     input logic odd);
		vga_color_t res;
		res = v;
		if (odd) begin
			case (mode)
				SCAN_NONE:  res = v;
				SCAN_HQ2X:  res = v;
				SCAN_DIM25: res = v - (v >> 2);
				SCAN_DIM50: res = v - (v >> 1);
			endcase
		end
		return res;
	endfunction

	// Bit replication spreads the core range over the full 6-bit scale
	assign exp_r = {core_pixel.r, core_pixel.r};
	assign exp_g = {core_pixel.g, core_pixel.g};
	assign exp_b = {core_pixel.b, core_pixel.b, core_pixel.b};
	assign blank = hblank | vblank;

	// ========================================
	// Output register
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga      <= '0;
			odd_line <= 1'b0;
		end else if (ce_pix) begin
			// vga.hs and vga.vs hold the syncs of the previous pixel
			if (vsync && !vga.vs) begin
				odd_line <= 1'b0;
			end else if (hsync && !vga.hs) begin
				odd_line <= ~odd_line;
			end
			if (blank) begin
				vga.r <= '0;
				vga.g <= '0;
				vga.b <= '0;
			end else begin
				vga.r <= shade(exp_r, scan_mode, odd_line);
				vga.g <= shade(exp_g, scan_mode, odd_line);
				vga.b <= shade(exp_b, scan_mode, odd_line);
			end
			vga.hs <= hsync;
			vga.vs <= vsync;
		end
	end

endmodule

`default_nettype wire

// ==== design/player_input_mapper.sv ====
// Cabinet input mapper
`default_nettype none
`timescale 1ns/1ns

module player_input_mapper (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire shell_pkg::key_state_t  key_state,
	input  wire shell_pkg::joystick_t   joystick_0,
	input  wire shell_pkg::joystick_t   joystick_1,
	input  wire                         upright,
	output shell_pkg::cabinet_buttons_t cabinet_buttons
);

	import shell_pkg::*;

	joystick_t        joy_any;
	logic             in_up;
	logic             in_down;
	logic             in_left;
	logic             in_right;
	logic             m_up;
	logic             m_down;
	logic             m_left;
	logic             m_right;
	logic             m_fire;
	cabinet_buttons_t buttons_next;

	assign joy_any  = joystick_0 | joystick_1;

	assign in_up    = key_state[KEY_UP]    | joy_any[JOY_UP];
	assign in_down  = key_state[KEY_DOWN]  | joy_any[JOY_DOWN];
	assign in_left  = key_state[KEY_LEFT]  | joy_any[JOY_LEFT];
	assign in_right = key_state[KEY_RIGHT] | joy_any[JOY_RIGHT];

	// Upright cabinet turns the playfield by 90 degrees
	assign m_up     = upright ? in_right : in_up;
	assign m_down   = upright ? in_left  : in_down;
	assign m_left   = upright ? in_up    : in_left;
	assign m_right  = upright ? in_down  : in_right;

	assign m_fire   = key_state[KEY_FIRE] | joy_any[JOY_FIRE];

	always_comb begin
		buttons_next.coin   = ~{1'b0, key_state[KEY_COIN]};
		buttons_next.fire   = ~{1'b0, m_fire};
		buttons_next.bomb   = ~{1'b0, key_state[KEY_BOMB]};
		buttons_next.tilt   = 2'b11;
		buttons_next.select = ~{key_state[KEY_START2], key_state[KEY_START1]};
		buttons_next.up     = ~{1'b0, m_up};
		buttons_next.down   = ~{1'b0, m_down};
		buttons_next.left   = ~{1'b0, m_left};
		buttons_next.right  = ~{1'b0, m_right};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cabinet_buttons <= '1;
		end else begin
			cabinet_buttons <= buttons_next;
		end
	end

endmodule

`default_nettype wire

// ==== design/ps2_keyboard.sv ====
// PS/2 keyboard control decoder
`default_nettype none
`timescale 1ns/1ns

module ps2_keyboard (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   ps2_kbd_clk,
	input  wire                   ps2_kbd_data,
	output shell_pkg::key_state_t key_state
);

	import shell_pkg::*;

	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	logic       clk_prev;
	logic       clk_fall;
	logic [3:0] bit_cnt;
	logic [9:0] shift;
	logic       parity_ok;
	logic       rx_valid;
	scancode_t  rx_byte;
	logic       brk_pending;
	logic       ext_pending;
	key_state_t key_hit;

	assign clk_fall = clk_prev & ~clk_sync[1];

	// Shift holds start, eight data bits and parity, start bit at the bottom
	assign parity_ok = ^shift[9:1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_kbd_clk};
			dat_sync <= {dat_sync[0], ps2_kbd_data};
			clk_prev <= clk_sync[1];
		end
	end

	// ========================================
	// Frame receiver
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					// Stop bit on the line now, good frames only are passed on
					bit_cnt  <= '0;
					rx_valid <= dat_sync[1] & parity_ok;
				end else if (bit_cnt != 4'd0 || !dat_sync[1]) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (clk_fall && bit_cnt != 4'd10 && (bit_cnt != 4'd0 || !dat_sync[1])) begin
			shift <= {dat_sync[1], shift[9:1]};
		end
		if (clk_fall && bit_cnt == 4'd10) begin
			rx_byte <= shift[8:1];
		end
	end

	// ========================================
	// Scancode decode
	// ========================================
	always_comb begin
		key_hit = '0;
		if (ext_pending) begin
			case (rx_byte)
				SC_UP:    key_hit[KEY_UP]    = 1'b1;
				SC_DOWN:  key_hit[KEY_DOWN]  = 1'b1;
				SC_LEFT:  key_hit[KEY_LEFT]  = 1'b1;
				SC_RIGHT: key_hit[KEY_RIGHT] = 1'b1;
				default:  key_hit = '0;
			endcase
		end else begin
			case (rx_byte)
				SC_SPACE: key_hit[KEY_FIRE]   = 1'b1;
				SC_1:     key_hit[KEY_START1] = 1'b1;
				SC_2:     key_hit[KEY_START2] = 1'b1;
				SC_5:     key_hit[KEY_COIN]   = 1'b1;
				SC_Z:     key_hit[KEY_BOMB]   = 1'b1;
				default:  key_hit = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_state   <= '0;
			brk_pending <= 1'b0;
			ext_pending <= 1'b0;
		end else if (rx_valid) begin
			if (rx_byte == SC_BREAK) begin
				brk_pending <= 1'b1;
			end else if (rx_byte == SC_EXT) begin
				ext_pending <= 1'b1;
			end else begin
				brk_pending <= 1'b0;
				ext_pending <= 1'b0;
				if (brk_pending) begin
					key_state <= key_state & ~key_hit;
				end else begin
					key_state <= key_state | key_hit;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/shell_control.sv ====
// Core reset and option control
`default_nettype none
`timescale 1ns/1ns

module shell_control (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire shell_pkg::status_word_t status,
	input  wire [1:0]               menu_buttons,
	input  wire                     vblank,
	output logic                    core_reset,
	output logic                    upright,
	output shell_pkg::scan_mode_t   scan_mode
);

	import shell_pkg::*;

	typedef enum logic [1:0] {
		CTL_HOLD,
		CTL_STRETCH,
		CTL_RUN
	} ctl_state_t;

	ctl_state_t   state;
	reset_count_t count;
	logic         core_req;
	logic         vblank_prev;

	// Reset requests from the menu and the OSD button
	assign core_req = status[STATUS_RESET] | status[STATUS_RESET_ALT] | menu_buttons[1];

	// Held while any request is present, so the output never lags a request
	assign core_reset = reset | core_req | (state != CTL_RUN);

	// ========================================
	// Reset stretch FSM
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset || core_req) begin
			state <= CTL_HOLD;
			count <= '0;
		end else begin
			case (state)
				CTL_HOLD: begin
					state <= CTL_STRETCH;
					count <= '0;
				end
				CTL_STRETCH: begin
					// The cycle leaving CTL_HOLD already counts as the first stretch cycle
					if (count == reset_count_t'(CORE_RESET_CYCLES - 2)) begin
						state <= CTL_RUN;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: begin
					state <= CTL_RUN;
				end
			endcase
		end
	end

	// ========================================
	// Option latching
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			upright     <= 1'b0;
			scan_mode   <= SCAN_NONE;
			vblank_prev <= 1'b0;
		end else begin
			upright     <= status[STATUS_UPRIGHT];
			vblank_prev <= vblank;
			// Scanline changes wait for vertical blanking to avoid a torn frame
			if (vblank && !vblank_prev) begin
				scan_mode <= status[STATUS_SCAN_LO +: 2];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/shell_pkg.sv ====
// Arcade shell shared definitions
`default_nettype none

package shell_pkg;

	// ========================================
	// Menu status word
	// ========================================
	typedef logic [31:0] status_word_t;

	localparam int STATUS_RESET     = 0;
	localparam int STATUS_UPRIGHT   = 2;
	// Scanline option occupies this bit and the one above it
	localparam int STATUS_SCAN_LO   = 3;
	localparam int STATUS_RESET_ALT = 6;

	typedef logic [1:0] scan_mode_t;

	localparam scan_mode_t SCAN_NONE  = 2'd0;
	localparam scan_mode_t SCAN_HQ2X  = 2'd1;
	localparam scan_mode_t SCAN_DIM25 = 2'd2;
	localparam scan_mode_t SCAN_DIM50 = 2'd3;

	localparam int CORE_RESET_CYCLES = 16;
	typedef logic [$clog2(CORE_RESET_CYCLES)-1:0] reset_count_t;

	// ========================================
	// Player controls
	// ========================================
	typedef logic [7:0] joystick_t;

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	typedef logic [8:0] key_state_t;

	localparam int KEY_FIRE   = 0;
	localparam int KEY_START1 = 1;
	localparam int KEY_START2 = 2;
	localparam int KEY_COIN   = 3;
	localparam int KEY_UP     = 4;
	localparam int KEY_DOWN   = 5;
	localparam int KEY_LEFT   = 6;
	localparam int KEY_RIGHT  = 7;
	localparam int KEY_BOMB   = 8;

	// Active-low cabinet inputs, bit 0 of every field is player one
	typedef struct packed {
		logic [1:0] coin;
		logic [1:0] fire;
		logic [1:0] bomb;
		logic [1:0] tilt;
		logic [1:0] select;
		logic [1:0] up;
		logic [1:0] down;
		logic [1:0] left;
		logic [1:0] right;
	} cabinet_buttons_t;

	// PS/2 set 2 scancodes
	typedef logic [7:0] scancode_t;

	localparam scancode_t SC_SPACE = 8'h29;
	localparam scancode_t SC_1     = 8'h16;
	localparam scancode_t SC_2     = 8'h1E;
	localparam scancode_t SC_5     = 8'h2E;
	localparam scancode_t SC_Z     = 8'h1A;
	localparam scancode_t SC_UP    = 8'h75;
	localparam scancode_t SC_DOWN  = 8'h72;
	localparam scancode_t SC_LEFT  = 8'h6B;
	localparam scancode_t SC_RIGHT = 8'h74;
	localparam scancode_t SC_EXT   = 8'hE0;
	localparam scancode_t SC_BREAK = 8'hF0;

	// ========================================
	// Video and audio
	// ========================================
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} core_pixel_t;

	typedef logic [5:0] vga_color_t;

	typedef struct packed {
		vga_color_t r;
		vga_color_t g;
		vga_color_t b;
		logic       hs;
		logic       vs;
	} vga_out_t;

	typedef logic signed [7:0] audio_sample_t;
	typedef logic [15:0] dac_word_t;

endpackage

`default_nettype wire

// ==== design/sigma_delta_dac.sv ====
// First-order sigma-delta audio DAC
`default_nettype none
`timescale 1ns/1ns

module sigma_delta_dac (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire shell_pkg::audio_sample_t audio,
	output logic                          dac_out
);

	import shell_pkg::*;

	dac_word_t   offset;
	dac_word_t   acc;
	logic [16:0] sum;

	// Signed sample to offset binary, scaled into the top byte
	assign offset = {~audio[7], audio[6:0], 8'h00};
	assign sum    = {1'b0, acc} + {1'b0, offset};

	// Carry density follows the offset value
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[15:0];
			dac_out <= sum[16];
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/shell_pkg.sv
design/shell_control.sv
design/ps2_keyboard.sv
design/player_input_mapper.sv
design/pixel_output.sv
design/sigma_delta_dac.sv
design/arcade_shell_top.sv
tb/arcade_shell_assert.sv
tb/arcade_shell_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module arcade_shell_tb -f filelist.f -o arcade_shell_sim

out=$(./obj_dir/arcade_shell_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

// ==== tb/arcade_shell_assert.sv ====
// Shell output assertions
`default_nettype none
`timescale 1ns/1ns

module arcade_shell_assert (
	input wire                      clk_sys,
	input wire                      reset,
	input wire                      core_reset,
	input wire                      audio_l,
	input wire                      audio_r,
	input wire                      ce_pix,
	input wire                      hblank,
	input wire                      vblank,
	input wire shell_pkg::vga_out_t vga
);

	// ========================================
	// Reset and audio
	// ========================================
	reset_holds_core: assert property (@(posedge clk_sys) reset |-> core_reset)
		else $error("core_reset low while reset is high");

	audio_mirror: assert property (@(posedge clk_sys) audio_r == audio_l)
		else $error("audio_r differs from audio_l");

	// Blanked pixels come out black one pixel later
	blank_black: assert property (@(posedge clk_sys) disable iff (reset)
		ce_pix && (hblank || vblank) |=> vga.r == '0 && vga.g == '0 && vga.b == '0)
		else $error("vga colour not zero after a blanked pixel");

endmodule

`default_nettype wire

// ==== tb/arcade_shell_tb.sv ====
// Arcade shell testbench
`default_nettype none
`timescale 1ns/1ns

module arcade_shell_tb;

	import shell_pkg::*;

	localparam int CLK_HALF   = 50;
	localparam int WAIT_LIMIT = 200;
	localparam int PS2_HALF   = 6;

	logic             clk_sys = 1'b0;
	logic             reset;
	status_word_t     status;
	logic [1:0]       menu_buttons;
	logic             ps2_kbd_clk;
	logic             ps2_kbd_data;
	joystick_t        joystick_0;
	joystick_t        joystick_1;
	core_pixel_t      core_pixel;
	logic             ce_pix;
	logic             hsync;
	logic             vsync;
	logic             hblank;
	logic             vblank;
	audio_sample_t    audio;
	logic             core_reset;
	cabinet_buttons_t cabinet_buttons;
	vga_out_t         vga;
	logic             audio_l;
	logic             audio_r;

	int          checks = 0;
	int          value_errors = 0;
	int          timeouts = 0;
	logic [31:0] lcg_state = 32'd7245;

	// Line parity and scanline mode as the pixel stage should see them
	logic       model_odd;
	logic       model_prev_hs;
	logic       model_prev_vs;
	scan_mode_t model_mode;

	always #CLK_HALF clk_sys = ~clk_sys;

	arcade_shell_top dut (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.status          (status),
		.menu_buttons    (menu_buttons),
		.ps2_kbd_clk     (ps2_kbd_clk),
		.ps2_kbd_data    (ps2_kbd_data),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.core_pixel      (core_pixel),
		.ce_pix          (ce_pix),
		.hsync           (hsync),
		.vsync           (vsync),
		.hblank          (hblank),
		.vblank          (vblank),
		.audio           (audio),
		.core_reset      (core_reset),
		.cabinet_buttons (cabinet_buttons),
		.vga             (vga),
		.audio_l         (audio_l),
		.audio_r         (audio_r)
	);

	bind arcade_shell_top arcade_shell_assert u_assert (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.core_reset (core_reset),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.ce_pix     (ce_pix),
		.hblank     (hblank),
		.vblank     (vblank),
		.vga        (vga)
	);

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_word(input string name, input logic [63:0] expected,
	                          input logic [63:0] actual);
		checks++;
		assert (actual == expected) else begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			value_errors++;
		end
	endtask

	// Counts falling clock edges until the core leaves reset
	task automatic wait_reset_release(output int cycles);
		cycles = 0;
		while (core_reset && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		assert (!core_reset) else begin
			$display("Timeout: core reset never released");
			timeouts++;
		end
	endtask

	task automatic wait_buttons(input string name, input cabinet_buttons_t expected);
		int cycles;
		cycles = 0;
		while (cabinet_buttons != expected && cycles < WAIT_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_word(name, 64'(expected), 64'(cabinet_buttons));
	endtask

	task automatic send_ps2_bit(input logic b);
		ps2_kbd_data = b;
		repeat (PS2_HALF) @(negedge clk_sys);
		ps2_kbd_clk = 1'b0;
		repeat (PS2_HALF) @(negedge clk_sys);
		ps2_kbd_clk = 1'b1;
	endtask

	// Start bit, data LSB first, odd parity, stop bit
	task automatic send_ps2_byte(input logic [7:0] code, input logic bad_parity);
		logic parity;
		parity = ~(^code) ^ bad_parity;
		send_ps2_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			send_ps2_bit(code[i]);
		end
		send_ps2_bit(parity);
		send_ps2_bit(1'b1);
		repeat (PS2_HALF) @(negedge clk_sys);
	endtask

	function automatic vga_color_t dim(input int v, input scan_mode_t mode);
		int res;
		res = v;
		if (mode == SCAN_DIM50) begin
			res = v - v / 2;
		end else if (mode == SCAN_DIM25) begin
			res = v - v / 4;
		end
		return vga_color_t'(res);
	endfunction

	// Drives one pixel with ce_pix high and checks it on the following cycle
	task automatic pixel_step(input string name, input core_pixel_t pix, input logic hs,
	                          input logic vs, input logic hb, input logic vb);
		vga_out_t   exp;
		scan_mode_t mode_now;
		ce_pix     = 1'b1;
		core_pixel = pix;
		hsync      = hs;
		vsync      = vs;
		hblank     = hb;
		vblank     = vb;
		mode_now = model_odd ? model_mode : SCAN_NONE;
		exp.r  = dim(int'(pix.r) * 9, mode_now);
		exp.g  = dim(int'(pix.g) * 9, mode_now);
		exp.b  = dim(int'(pix.b) * 21, mode_now);
		exp.hs = hs;
		exp.vs = vs;
		if (hb || vb) begin
			exp.r = '0;
			exp.g = '0;
			exp.b = '0;
		end
		if (vs && !model_prev_vs) begin
			model_odd = 1'b0;
		end else if (hs && !model_prev_hs) begin
			model_odd = ~model_odd;
		end
		model_prev_hs = hs;
		model_prev_vs = vs;
		@(negedge clk_sys);
		check_word(name, 64'(exp), 64'(vga));
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic test_reset_stretch();
		int cycles;
		wait_reset_release(cycles);
		status[STATUS_RESET_ALT] = 1'b1;
		repeat (3) @(negedge clk_sys);
		check_word("reset_stretch_hold", 64'(1'b1), 64'(core_reset));
		status[STATUS_RESET_ALT] = 1'b0;
		wait_reset_release(cycles);
		check_word("reset_stretch_length", 64'(CORE_RESET_CYCLES), 64'(cycles));
	endtask

	task automatic test_keyboard();
		cabinet_buttons_t exp;
		exp = '1;
		send_ps2_byte(SC_5, 1'b0);
		exp.coin = 2'b10;
		wait_buttons("keyboard_coin_press", exp);
		send_ps2_byte(SC_BREAK, 1'b0);
		send_ps2_byte(SC_5, 1'b0);
		exp.coin = 2'b11;
		wait_buttons("keyboard_coin_release", exp);
		send_ps2_byte(SC_EXT, 1'b0);
		send_ps2_byte(SC_UP, 1'b0);
		exp.up = 2'b10;
		wait_buttons("keyboard_ext_up", exp);
		send_ps2_byte(SC_5, 1'b1);
		wait_buttons("keyboard_bad_parity", exp);
		send_ps2_byte(SC_EXT, 1'b0);
		send_ps2_byte(SC_BREAK, 1'b0);
		send_ps2_byte(SC_UP, 1'b0);
		exp.up = 2'b11;
		wait_buttons("keyboard_up_release", exp);
	endtask

	task automatic test_orientation();
		cabinet_buttons_t exp;
		logic [31:0]      r;
		joystick_t        any;
		logic             up_mode;
		logic             d_up;
		logic             d_down;
		logic             d_left;
		logic             d_right;
		for (int n = 0; n < 16; n++) begin
			r = lcg_next();
			up_mode = (n >= 8);
			joystick_0 = joystick_t'(r[15:8]);
			joystick_1 = joystick_t'(r[23:16]);
			status[STATUS_UPRIGHT] = up_mode;
			any = joystick_0 | joystick_1;
			// Upright turns the stick a quarter turn
			if (up_mode) begin
				d_up    = any[JOY_RIGHT];
				d_down  = any[JOY_LEFT];
				d_left  = any[JOY_UP];
				d_right = any[JOY_DOWN];
			end else begin
				d_up    = any[JOY_UP];
				d_down  = any[JOY_DOWN];
				d_left  = any[JOY_LEFT];
				d_right = any[JOY_RIGHT];
			end
			exp = '1;
			exp.fire  = {1'b1, ~any[JOY_FIRE]};
			exp.up    = {1'b1, ~d_up};
			exp.down  = {1'b1, ~d_down};
			exp.left  = {1'b1, ~d_left};
			exp.right = {1'b1, ~d_right};
			// One cycle for upright, one for the mapper register
			repeat (2) @(negedge clk_sys);
			if (up_mode) begin
				check_word("orientation_upright", 64'(exp), 64'(cabinet_buttons));
			end else begin
				check_word("orientation_normal", 64'(exp), 64'(cabinet_buttons));
			end
		end
		joystick_0 = '0;
		joystick_1 = '0;
		status[STATUS_UPRIGHT] = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic test_colour();
		logic [31:0] r;
		logic        hb;
		model_mode = SCAN_NONE;
		for (int n = 0; n < 24; n++) begin
			r = lcg_next();
			hb = (r[27:26] == 2'b00) || (n == 5);
			pixel_step("colour", core_pixel_t'(r[23:16]), 1'b0, 1'b0, hb, 1'b0);
		end
	endtask

	task automatic test_scanlines();
		core_pixel_t pix;
		pix = core_pixel_t'(8'hFF);
		status[STATUS_SCAN_LO +: 2] = SCAN_DIM50;
		// Odd line before any vblank edge, so still undimmed
		pixel_step("scan_hsync", pix, 1'b1, 1'b0, 1'b1, 1'b0);
		pixel_step("scan_before_vblank", pix, 1'b0, 1'b0, 1'b0, 1'b0);
		pixel_step("scan_vblank", pix, 1'b0, 1'b1, 1'b0, 1'b1);
		model_mode = SCAN_DIM50;
		pixel_step("scan_vblank_hold", pix, 1'b0, 1'b0, 1'b0, 1'b1);
		pixel_step("scan_first_line", pix, 1'b0, 1'b0, 1'b0, 1'b0);
		for (int line = 0; line < 4; line++) begin
			pixel_step("scan_hsync", pix, 1'b1, 1'b0, 1'b1, 1'b0);
			for (int k = 0; k < 3; k++) begin
				pix = core_pixel_t'(lcg_next() >> 16);
				if (model_odd) begin
					pixel_step("scan_odd_line", pix, 1'b0, 1'b0, 1'b0, 1'b0);
				end else begin
					pixel_step("scan_even_line", pix, 1'b0, 1'b0, 1'b0, 1'b0);
				end
			end
		end
	endtask

	task automatic test_audio(input audio_sample_t value);
		int ones_l;
		int ones_r;
		int expected;
		// Offset binary of a signed byte is its value plus half scale
		expected = int'(value) + 128;
		ones_l = 0;
		ones_r = 0;
		audio = value;
		repeat (256) begin
			@(negedge clk_sys);
			ones_l = ones_l + (audio_l ? 1 : 0);
			ones_r = ones_r + (audio_r ? 1 : 0);
		end
		check_word("audio_density_left", 64'(expected), 64'(ones_l));
		check_word("audio_density_right", 64'(expected), 64'(ones_r));
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		reset         = 1'b1;
		status        = '0;
		menu_buttons  = '0;
		ps2_kbd_clk   = 1'b1;
		ps2_kbd_data  = 1'b1;
		joystick_0    = '0;
		joystick_1    = '0;
		core_pixel    = '0;
		ce_pix        = 1'b0;
		hsync         = 1'b0;
		vsync         = 1'b0;
		hblank        = 1'b0;
		vblank        = 1'b0;
		audio         = '0;
		model_odd     = 1'b0;
		model_prev_hs = 1'b0;
		model_prev_vs = 1'b0;
		model_mode    = SCAN_NONE;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;

		test_reset_stretch();
		test_keyboard();
		test_orientation();
		test_colour();
		test_scanlines();
		test_audio(audio_sample_t'(8'h00));
		test_audio(audio_sample_t'(8'hC0));
		test_audio(audio_sample_t'(8'h7F));

		$display("Checks: %0d, value errors: %0d, timeouts: %0d",
		         checks, value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
